/* build.f */
+incdir+include
logic/deser_pkg.sv
logic/flit_slot_counter.sv
logic/deser_ctrl_fsm.sv
logic/flit_assembler.sv
logic/flow_deserializer.sv
verif/tb_flow_deserializer.sv

/* include/deser_cfg.svh */
`ifndef DESER_CFG_SVH
`define DESER_CFG_SVH

// --------------------
// Flit and word widths
// --------------------

// Width of one push flit in bits
`define DESER_PUSH_WIDTH 8

// Width of the assembled pop word in bits
// Must be a multiple of the push width and larger than it
`define DESER_POP_WIDTH 32

// --------------------
// Flit order
// --------------------

// 1 places the first flit of a packet in the most significant bits of the word
// 0 places the first flit in the least significant bits
`define DESER_MSB_FIRST 1

`endif

/* logic/deser_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module deser_ctrl_fsm (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    push_valid,
  input  deser_pkg::slot_idx_t    push_id,
  input  logic                    push_last,
  input  logic                    pop_ready,
  input  logic                    id_mismatch,
  output logic                    push_ready,
  output logic                    pop_valid,
  output logic                    advance,
  output logic                    restart,
  output logic                    store_en,
  output deser_pkg::slot_idx_t    store_idx,
  output logic                    clear,
  output deser_pkg::deser_state_e state,
  output logic                    id_error
);

  import deser_pkg::*;

  logic         id_zero;
  logic         last_flit;
  logic         accept;
  logic         discard;
  deser_state_e state_nxt;

  // --------------------
  // Flit decode
  // --------------------

  assign id_zero = (push_id == '0);

  // A matching last flit means every earlier slot has already been filled
  assign last_flit = push_valid && (push_id == LAST_ID) && !id_mismatch;

  // Only the last flit can be held back, and only by the pop side
  assign push_ready = !last_flit || pop_ready;
  assign accept     = push_valid && push_ready;

  // The word pops in the same cycle as its last flit
  assign pop_valid = last_flit;

  // --------------------
  // Datapath control
  // --------------------

  // A good nonzero flit moves the counter on, including the last one
  assign advance = accept && !id_mismatch && !id_zero;

  // Id 0 and bad ids both resynchronize the counter
  assign restart = accept && (id_zero || id_mismatch);

  // The last flit is never stored, it feeds pop_data directly
  assign store_en  = accept && !id_mismatch && (push_id != LAST_ID);
  assign store_idx = push_id;

  // Losing a partial packet is an error: a bad id anywhere, or id 0 arriving
  // while earlier flits are still held
  assign discard = accept && (id_mismatch || (id_zero && (state != IDLE)));
  assign clear   = discard;

  // --------------------
  // State machine
  // --------------------

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (accept && id_zero) begin
          state_nxt = COLLECT;
        end
      end
      COLLECT, LAST_WAIT: begin
        if (accept && id_mismatch) begin
          state_nxt = IDLE;
        end else if (accept && id_zero) begin
          state_nxt = COLLECT;
        end else if (last_flit) begin
          state_nxt = pop_ready ? IDLE : LAST_WAIT;
        end else begin
          state_nxt = COLLECT;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      id_error <= 1'b0;
    end else begin
      state    <= state_nxt;
      // Error pulse shows up the cycle after the dropped flit
      id_error <= discard;
    end
  end

  // The sender must flag the final flit consistently with its id
  a_last_id_has_last: assert property (
    @(posedge clk) disable iff (!arst_n)
    (push_valid && (push_id == LAST_ID)) |-> push_last
  ) else $error("flit with last id %0d arrived without push_last", push_id);

  a_pop_needs_last: assert property (
    @(posedge clk) disable iff (!arst_n)
    pop_valid |-> push_last
  ) else $error("pop_valid without push_last on the push side");

  // A pulse only stretches when a new packet was lost in the same cycle
  a_id_error_pulse: assert property (
    @(posedge clk) disable iff (!arst_n)
    id_error |=> (!id_error || $past(discard))
  ) else $error("id_error held high without a new discard");

endmodule

`default_nettype wire

/* logic/deser_pkg.sv */
`default_nettype none

`include "deser_cfg.svh"

package deser_pkg;

  // Number of push flits that make up one pop word
  localparam int NUM_FLITS = `DESER_POP_WIDTH / `DESER_PUSH_WIDTH;

  // Width of the flit id that travels with each push flit
  localparam int SLOT_W = $clog2(NUM_FLITS);

  // Flit id and slot index share one type
  typedef logic [SLOT_W-1:0] slot_idx_t;

  // Id of the final flit of a packet, which goes straight to the pop side
  localparam slot_idx_t LAST_ID = slot_idx_t'(NUM_FLITS - 1);

  typedef logic [`DESER_PUSH_WIDTH-1:0] push_flit_t;
  typedef logic [`DESER_POP_WIDTH-1:0] pop_word_t;

  // IDLE has nothing stored, COLLECT holds a partial packet,
  // LAST_WAIT has the last flit waiting on pop_ready
  typedef enum logic [1:0] {
    IDLE      = 2'd0,
    COLLECT   = 2'd1,
    LAST_WAIT = 2'd2
  } deser_state_e;

endpackage

`default_nettype wire

/* logic/flit_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deser_cfg.svh"

module flit_assembler (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 store_en,
  input  deser_pkg::slot_idx_t store_idx,
  input  logic                 clear,
  input  deser_pkg::push_flit_t push_data,
  output deser_pkg::pop_word_t  pop_data
);

  import deser_pkg::*;

  localparam int FLIT_W    = $bits(push_flit_t);
  localparam bit MSB_FIRST = (`DESER_MSB_FIRST != 0);

  // Slots for every flit except the last, indexed by flit id
  push_flit_t [NUM_FLITS-2:0] slot_q;

  // All flits of the packet in arrival order, last flit taken live
  push_flit_t [NUM_FLITS-1:0] flits;

  // --------------------
  // Slot storage
  // --------------------

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      slot_q <= '0;
    end else begin
      for (int i = 0; i < NUM_FLITS - 1; i++) begin
        // A new id-0 flit writes slot 0 while the discard wipes the rest
        if (store_en && (store_idx == slot_idx_t'(i))) begin
          slot_q[i] <= push_data;
        end else if (clear) begin
          slot_q[i] <= '0;
        end
      end
    end
  end

  // --------------------
  // Word assembly
  // --------------------

  // Index NUM_FLITS-1 holds the live flit, so this is plain arrival order
  assign flits = {push_data, slot_q};

  // With MSB first the first flit lands at the top of the word
  // and the bit order inside each flit is never changed
  always_comb begin
    int pos;
    pop_data = '0;
    for (int i = 0; i < NUM_FLITS; i++) begin
      if (MSB_FIRST) begin
        pos = NUM_FLITS - 1 - i;
      end else begin
        pos = i;
      end
      pop_data[pos*FLIT_W +: FLIT_W] = flits[i];
    end
  end

  // The controller must never try to park the last flit in a slot
  a_store_idx_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    store_en |-> (store_idx < LAST_ID)
  ) else $error("store into slot %0d which is not a storage slot", store_idx);

endmodule

`default_nettype wire

/* logic/flit_slot_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module flit_slot_counter (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 push_valid,
  input  deser_pkg::slot_idx_t push_id,
  input  logic                 advance,
  input  logic                 restart,
  output deser_pkg::slot_idx_t expected_id,
  output logic                 id_mismatch
);

  import deser_pkg::*;

  slot_idx_t expected_nxt;

  // --------------------
  // Next expected id
  // --------------------

  // Restart wins over advance since a restarting flit is never a good
  // continuation of the current packet
  always_comb begin
    expected_nxt = expected_id;
    if (restart) begin
      // An id-0 flit opens a new packet and was stored as slot 0,
      // so slot 1 comes next
      // A mismatching flit leaves nothing behind and we wait for a fresh id 0
      if (push_id == '0) begin
        expected_nxt = slot_idx_t'(1);
      end else begin
        expected_nxt = '0;
      end
    end else if (advance) begin
      // Wrap after the last flit so the next packet starts at id 0
      if (expected_id == LAST_ID) begin
        expected_nxt = '0;
      end else begin
        expected_nxt = expected_id + slot_idx_t'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      expected_id <= '0;
    end else begin
      expected_id <= expected_nxt;
    end
  end

  // --------------------
  // Sequence check
  // --------------------

  // Id 0 is never a mismatch because it always restarts a packet
  // Any other id must be exactly the one we expect
  assign id_mismatch = push_valid && (push_id != '0) && (push_id != expected_id);

  // The counter must stay inside the packet even when NUM_FLITS is not a power of two
  a_expected_in_range: assert property (
    @(posedge clk) disable iff (!arst_n)
    expected_id <= LAST_ID
  ) else $error("expected_id %0d beyond last flit id %0d", expected_id, LAST_ID);

endmodule

`default_nettype wire

/* logic/flow_deserializer.sv */
`timescale 1ns/1ps
`default_nettype none

module flow_deserializer (
  input  logic                  clk,
  input  logic                  arst_n,

  // Narrow push side, one flit per transfer
  input  logic                  push_valid,
  input  deser_pkg::push_flit_t push_data,
  input  deser_pkg::slot_idx_t  push_id,
  input  logic                  push_last,
  output logic                  push_ready,

  // Wide pop side, one whole packet per transfer
  input  logic                  pop_ready,
  output logic                  pop_valid,
  output deser_pkg::pop_word_t  pop_data,

  // Pulses once for every packet lost to a sequence error
  output logic                  id_error
);

  import deser_pkg::*;

  // --------------------
  // Internal wires
  // --------------------

  logic      id_mismatch;
  logic      advance;
  logic      restart;
  logic      store_en;
  slot_idx_t store_idx;
  logic      clear;

  // Tracks which flit id should come next
  flit_slot_counter u_counter (
    .clk         (clk),
    .arst_n      (arst_n),
    .push_valid  (push_valid),
    .push_id     (push_id),
    .advance     (advance),
    .restart     (restart),
    .expected_id (),
    .id_mismatch (id_mismatch)
  );

  // Handshakes, slot writes and error reporting
  deser_ctrl_fsm u_ctrl (
    .clk         (clk),
    .arst_n      (arst_n),
    .push_valid  (push_valid),
    .push_id     (push_id),
    .push_last   (push_last),
    .pop_ready   (pop_ready),
    .id_mismatch (id_mismatch),
    .push_ready  (push_ready),
    .pop_valid   (pop_valid),
    .advance     (advance),
    .restart     (restart),
    .store_en    (store_en),
    .store_idx   (store_idx),
    .clear       (clear),
    .state       (),
    .id_error    (id_error)
  );

  // Slot registers plus the ordered word
  flit_assembler u_assembler (
    .clk       (clk),
    .arst_n    (arst_n),
    .store_en  (store_en),
    .store_idx (store_idx),
    .clear     (clear),
    .push_data (push_data),
    .pop_data  (pop_data)
  );

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the flow deserializer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f \
  --top-module tb_flow_deserializer -o sim_deser
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_deser 2>&1)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTBENCH PASSED"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

/* verif/tb_flow_deserializer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "deser_cfg.svh"

module tb_flow_deserializer;

  import deser_pkg::*;

  localparam int FLIT_W         = `DESER_PUSH_WIDTH;
  localparam int N_BASIC        = 20;
  localparam int N_BACKPRESSURE = 30;
  localparam int N_GAPS         = 20;
  localparam int MAX_GAP        = 2;
  // Flits sent by the three directed error and reset tests
  localparam int DIRECTED_FLITS = 21;
  localparam int TOTAL_FLITS    = (N_BASIC + N_BACKPRESSURE + N_GAPS) * NUM_FLITS
                                  + DIRECTED_FLITS;
  localparam int CYCLE_LIMIT    = TOTAL_FLITS * 4 + 200;

  logic       clk;
  logic       arst_n;
  logic       push_valid;
  push_flit_t push_data;
  slot_idx_t  push_id;
  logic       push_last;
  logic       push_ready;
  logic       pop_ready;
  logic       pop_valid;
  pop_word_t  pop_data;
  logic       id_error;

  // Words that must pop, oldest first
  pop_word_t exp_q[$];

  int  fail_count;
  int  fails_at_start;
  int  test_num;
  int  error_pulses;
  int  exp_errors;
  int  cycle_count;
  bit  random_pop;

  flow_deserializer UUT (
    .clk        (clk),
    .arst_n     (arst_n),
    .push_valid (push_valid),
    .push_data  (push_data),
    .push_id    (push_id),
    .push_last  (push_last),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data),
    .id_error   (id_error)
  );

  always #20 clk = ~clk;

  // --------------------
  // Reference model
  // --------------------

  // With the first flit as MSB each new flit shifts in at the bottom and pushes
  // the earlier ones up, otherwise each new flit shifts in at the top and the
  // first one ends up at the bottom
  function automatic pop_word_t expected_word(input push_flit_t [NUM_FLITS-1:0] flits);
    pop_word_t word;
    word = '0;
    for (int i = 0; i < NUM_FLITS; i++) begin
      if (`DESER_MSB_FIRST != 0) begin
        word = {word[`DESER_POP_WIDTH-FLIT_W-1:0], flits[i]};
      end else begin
        word = {flits[i], word[`DESER_POP_WIDTH-1:FLIT_W]};
      end
    end
    return word;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("** Error @ %0t: %s, got %0h expected %0h", $time, what, got, exp);
      fail_count++;
    end
  endtask

  // --------------------
  // Stimulus helpers
  // --------------------

  task automatic idle_cycles(input int n);
    push_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Holds the flit until the DUT takes it, then returns 2 ns after that edge
  task automatic send_flit(input push_flit_t data, input slot_idx_t id, input logic last);
    logic taken;
    push_valid = 1'b1;
    push_data  = data;
    push_id    = id;
    push_last  = last;
    taken      = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = push_ready;
      @(posedge clk);
      #2;
    end
    push_valid = 1'b0;
    push_last  = 1'b0;
  endtask

  task automatic send_packet(input int max_gap);
    push_flit_t [NUM_FLITS-1:0] flits;
    int                         gap;
    for (int i = 0; i < NUM_FLITS; i++) begin
      flits[i] = push_flit_t'($urandom);
    end
    // Queued first because the word pops in the same cycle as the last flit
    exp_q.push_back(expected_word(flits));
    for (int i = 0; i < NUM_FLITS; i++) begin
      send_flit(flits[i], slot_idx_t'(i), (i == NUM_FLITS - 1));
      if (max_gap > 0) begin
        gap = int'($urandom % (max_gap + 1));
        idle_cycles(gap);
      end
    end
  endtask

  // First n flits of a packet that is never completed
  task automatic send_partial(input int n);
    for (int i = 0; i < n; i++) begin
      send_flit(push_flit_t'($urandom), slot_idx_t'(i), 1'b0);
    end
  endtask

  task automatic start_test();
    test_num++;
    fails_at_start = fail_count;
  endtask

  task automatic finish_test(input string name);
    idle_cycles(3);
    if (exp_q.size() != 0) begin
      $display("Test %0d: %0d expected words never popped", test_num, exp_q.size());
      fail_count++;
      exp_q.delete();
    end
    check_value(64'(error_pulses), 64'(exp_errors), "id_error pulse count");
    $display("Test %0d %s finished with %0d errors", test_num, name,
             fail_count - fails_at_start);
  endtask

  // --------------------
  // Pop side
  // --------------------

  always @(posedge clk) begin
    #2;
    if (random_pop) begin
      pop_ready = 1'($urandom % 2);
    end else begin
      pop_ready = 1'b1;
    end
  end

  // Inputs only move 2 ns after the rising edge, so the falling edge sees
  // settled values for both the combinational and the registered outputs
  always @(negedge clk) begin
    if (arst_n) begin
      if (pop_valid && pop_ready) begin
        if (exp_q.size() == 0) begin
          $display("Unexpected word %0h popped at %0t with none pending", pop_data, $time);
          fail_count++;
        end else begin
          check_value(64'(pop_data), 64'(exp_q.pop_front()), "pop_data");
        end
      end
      if (pop_valid) begin
        check_value(64'(push_valid && push_id == LAST_ID && push_last), 64'(1),
                    "pop_valid without a matching last flit");
      end
      if (!push_ready) begin
        check_value(64'(push_valid && push_id == LAST_ID && !pop_ready), 64'(1),
                    "push_ready low without a waiting last flit");
      end
      if (id_error) begin
        error_pulses++;
      end
    end
  end

  // Stops a stuck handshake from hanging the run
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    clk            = 1'b0;
    arst_n         = 1'b0;
    push_valid     = 1'b0;
    push_data      = '0;
    push_id        = '0;
    push_last      = 1'b0;
    pop_ready      = 1'b1;
    random_pop     = 1'b0;
    fail_count     = 0;
    fails_at_start = 0;
    test_num       = 0;
    error_pulses   = 0;
    exp_errors     = 0;
    cycle_count    = 0;
    void'($urandom(20668));

    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;
    idle_cycles(1);

    start_test();
    for (int p = 0; p < N_BASIC; p++) begin
      send_packet(0);
    end
    finish_test("back-to-back packets");

    start_test();
    random_pop = 1'b1;
    for (int p = 0; p < N_BACKPRESSURE; p++) begin
      send_packet(0);
    end
    random_pop = 1'b0;
    finish_test("pop back-pressure");

    start_test();
    for (int p = 0; p < N_GAPS; p++) begin
      send_packet(MAX_GAP);
    end
    finish_test("push gaps");

    // Slot 2 is expected, so id 3 is out of sequence and must be dropped
    start_test();
    send_partial(2);
    send_flit(push_flit_t'($urandom), LAST_ID, 1'b1);
    exp_errors++;
    idle_cycles(2);
    send_packet(0);
    finish_test("wrong id mid-packet");

    start_test();
    send_partial(2);
    exp_errors++;
    send_packet(0);
    finish_test("id 0 mid-packet");

    // A last-id flit held during reset would pop if the expected id survived
    // the reset, and would raise id_error if the error register were not held
    start_test();
    send_partial(3);
    arst_n     = 1'b0;
    push_valid = 1'b1;
    push_data  = push_flit_t'($urandom);
    push_id    = LAST_ID;
    push_last  = 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_value(64'(pop_valid), 64'(0), "pop_valid during reset");
      check_value(64'(id_error), 64'(0), "id_error during reset");
      check_value(64'(push_ready), 64'(1), "push_ready during reset");
    end
    @(posedge clk);
    #2;
    push_valid = 1'b0;
    push_last  = 1'b0;
    arst_n     = 1'b1;
    idle_cycles(1);
    send_packet(0);
    finish_test("reset mid-packet");

    $display("Tests run %0d, errors %0d, id_error pulses %0d, cycles %0d",
             test_num, fail_count, error_pulses, cycle_count);
    if (fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
